// ==== src/obi_xbar_pkg.sv ====
/* OBI crossbar shared definitions
   Bus widths, system address map and error slave constants */

`default_nettype none

package obi_xbar_pkg;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = 4;

  // Aggregated request word of we, be, addr and wdata
  localparam int unsigned REQ_DATA_WIDTH = 1 + BE_WIDTH + ADDR_WIDTH + DATA_WIDTH;

  // Error slave sits right after the external slave ports
  localparam int unsigned NUM_EXT_SLAVES = 3;
  localparam int unsigned ERROR_IDX = 3;

  // One address window with exclusive end address
  typedef struct packed {
    logic [31:0]           idx;
    logic [ADDR_WIDTH-1:0] start_addr;
    logic [ADDR_WIDTH-1:0] end_addr;
  } addr_rule_t;

  // System address map
  localparam addr_rule_t ADDR_RULES [NUM_EXT_SLAVES] = '{
    '{idx: 32'd0, start_addr: 32'h0000_0000, end_addr: 32'h0001_0000},
    '{idx: 32'd1, start_addr: 32'h0001_0000, end_addr: 32'h0002_0000},
    '{idx: 32'd2, start_addr: 32'h2000_0000, end_addr: 32'h2000_1000}
  };

  // Returned on every access outside the map
  localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hbadc_ab1e;

endpackage : obi_xbar_pkg

`default_nettype wire

// ==== src/addr_decode.sv ====
/* Address decoder
   Maps one master address onto a slave index using the system map,
   falling back to the error slave when no rule matches */

`timescale 1ns/1ps
`default_nettype none

module addr_decode
  import obi_xbar_pkg::*;
#(
  parameter int unsigned NSLAVE = NUM_EXT_SLAVES,
  parameter int unsigned IDX_WIDTH = 2
) (
  input  logic [ADDR_WIDTH-1:0] addr_i,
  output logic [IDX_WIDTH-1:0]  idx_o,
  output logic                  dec_error_o
);

  always_comb begin
    // Default target is the error slave
    idx_o       = IDX_WIDTH'(ERROR_IDX);
    dec_error_o = 1'b1;

    // Rules do not overlap, so at most one hits
    for (int unsigned i = 0; i < NSLAVE; i++) begin
      if ((addr_i >= ADDR_RULES[i].start_addr) &&
          (addr_i < ADDR_RULES[i].end_addr)) begin
        idx_o       = ADDR_RULES[i].idx[IDX_WIDTH-1:0];
        dec_error_o = 1'b0;
      end
    end
  end

endmodule : addr_decode

`default_nettype wire

// ==== src/rr_arbiter.sv ====
/* Round-robin arbiter
   Picks the first requester at or after a rotating pointer */

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NIN = 3,
  localparam int unsigned IDX_W = (NIN > 1) ? $clog2(NIN) : 1
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [NIN-1:0]   req_i,
  input  logic             accept_i,
  output logic [NIN-1:0]   sel_o,
  output logic [IDX_W-1:0] idx_o
);

  logic [IDX_W-1:0] ptr_q;
  logic             any_req;
  int unsigned      cand;

  // Scan from the pointer and wrap around once
  always_comb begin
    any_req = 1'b0;
    idx_o   = '0;
    cand    = 0;
    for (int unsigned off = 0; off < NIN; off++) begin
      cand = ptr_q + off;
      if (cand >= NIN) begin
        cand = cand - NIN;
      end
      if (!any_req && req_i[cand]) begin
        any_req = 1'b1;
        idx_o   = IDX_W'(cand);
      end
    end
  end

  assign sel_o = any_req ? (NIN'(1) << idx_o) : '0;

  // Move past the winner once the slave takes the transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (accept_i && any_req) begin
      if (idx_o == IDX_W'(NIN - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= idx_o + 1'b1;
      end
    end
  end

endmodule : rr_arbiter

`default_nettype wire

// ==== src/xbar_varlat.sv ====
/* Variable-latency crossbar
   Arbitrates masters per slave, forwards requests and grants, and
   returns responses in order through a per-slave queue of master indices */

`timescale 1ns/1ps
`default_nettype none

module xbar_varlat #(
  parameter int unsigned NIN = 3,
  parameter int unsigned NOUT = 4,
  parameter int unsigned REQ_WIDTH = 69,
  parameter int unsigned RESP_WIDTH = 32,
  localparam int unsigned SEL_W = (NOUT > 1) ? $clog2(NOUT) : 1,
  localparam int unsigned MIDX_W = (NIN > 1) ? $clog2(NIN) : 1
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Master side
  input  logic [NIN-1:0]                  req_i,
  input  logic [NIN-1:0][SEL_W-1:0]       sel_i,
  input  logic [NIN-1:0][REQ_WIDTH-1:0]   wdata_i,
  output logic [NIN-1:0]                  gnt_o,
  output logic [NIN-1:0]                  vld_o,
  output logic [NIN-1:0][RESP_WIDTH-1:0]  rdata_o,
  // Slave side
  output logic [NOUT-1:0]                 req_o,
  output logic [NOUT-1:0][REQ_WIDTH-1:0]  wdata_o,
  input  logic [NOUT-1:0]                 gnt_i,
  input  logic [NOUT-1:0]                 vld_i,
  input  logic [NOUT-1:0][RESP_WIDTH-1:0] rdata_i
);

  localparam int unsigned CNT_W = $clog2(NIN + 1);

  logic [NOUT-1:0][NIN-1:0]    out_req;
  logic [NOUT-1:0][NIN-1:0]    win_oh;
  logic [NOUT-1:0][MIDX_W-1:0] win_idx;
  logic [NOUT-1:0]             accept;
  logic [NOUT-1:0][MIDX_W-1:0] head_idx;
  logic [NOUT-1:0]             q_empty;

  function automatic logic [MIDX_W-1:0] next_ptr(input logic [MIDX_W-1:0] p);
    return (p == MIDX_W'(NIN - 1)) ? '0 : p + 1'b1;
  endfunction

  for (genvar k = 0; k < NOUT; k++) begin : gen_out
    logic [MIDX_W-1:0] q_mem [NIN];
    logic [MIDX_W-1:0] wr_ptr_q;
    logic [MIDX_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              pop;

    // Masters whose decoded target is this slave
    for (genvar i = 0; i < NIN; i++) begin : gen_match
      assign out_req[k][i] = req_i[i] && (sel_i[i] == SEL_W'(k));
    end

    rr_arbiter #(
      .NIN(NIN)
    ) u_arb (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (out_req[k]),
      .accept_i(accept[k]),
      .sel_o   (win_oh[k]),
      .idx_o   (win_idx[k])
    );

    assign req_o[k]   = |out_req[k];
    assign wdata_o[k] = wdata_i[win_idx[k]];
    assign accept[k]  = req_o[k] & gnt_i[k];

    // Order queue holds one entry per master
    assign pop         = vld_i[k] && !q_empty[k];
    assign q_empty[k]  = (cnt_q == '0);
    assign head_idx[k] = q_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
      if (accept[k]) begin
        q_mem[wr_ptr_q] <= win_idx[k];
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (accept[k]) begin
          wr_ptr_q <= next_ptr(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= next_ptr(rd_ptr_q);
        end
        if (accept[k] && !pop) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (!accept[k] && pop) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // Grant goes back only to the arbitration winner
  always_comb begin
    gnt_o = '0;
    for (int unsigned k = 0; k < NOUT; k++) begin
      for (int unsigned i = 0; i < NIN; i++) begin
        gnt_o[i] = gnt_o[i] | (win_oh[k][i] & gnt_i[k]);
      end
    end
  end

  // Steer each response to the master at the queue head
  always_comb begin
    vld_o   = '0;
    rdata_o = '0;
    for (int unsigned i = 0; i < NIN; i++) begin
      for (int unsigned k = 0; k < NOUT; k++) begin
        if (vld_i[k] && !q_empty[k] && (head_idx[k] == MIDX_W'(i))) begin
          vld_o[i]   = 1'b1;
          rdata_o[i] = rdata_i[k];
        end
      end
    end
  end

endmodule : xbar_varlat

`default_nettype wire

// ==== src/err_slave.sv ====
/* Error slave
   Grants every request and answers one cycle later with the error word */

`timescale 1ns/1ps
`default_nettype none

module err_slave
  import obi_xbar_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic pending_q;

  // Always ready
  assign gnt_o = req_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= req_i;
    end
  end

  assign rvalid_o = pending_q;
  assign rdata_o  = pending_q ? ERR_RDATA : '0;

endmodule : err_slave

`default_nettype wire

// ==== src/system_xbar.sv ====
/* System interconnect top
   Decodes master addresses, routes them through the crossbar to the
   external slaves, and catches unmapped accesses in the error slave */

`timescale 1ns/1ps
`default_nettype none

module system_xbar
  import obi_xbar_pkg::*;
#(
  parameter int unsigned NMASTER = 3,
  parameter int unsigned NSLAVE = NUM_EXT_SLAVES
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Masters
  input  logic [NMASTER-1:0]                    master_req_i,
  input  logic [NMASTER-1:0]                    master_we_i,
  input  logic [NMASTER-1:0][BE_WIDTH-1:0]      master_be_i,
  input  logic [NMASTER-1:0][ADDR_WIDTH-1:0]    master_addr_i,
  input  logic [NMASTER-1:0][DATA_WIDTH-1:0]    master_wdata_i,
  output logic [NMASTER-1:0]                    master_gnt_o,
  output logic [NMASTER-1:0]                    master_rvalid_o,
  output logic [NMASTER-1:0][DATA_WIDTH-1:0]    master_rdata_o,
  // External slaves
  output logic [NSLAVE-1:0]                     slave_req_o,
  output logic [NSLAVE-1:0]                     slave_we_o,
  output logic [NSLAVE-1:0][BE_WIDTH-1:0]       slave_be_o,
  output logic [NSLAVE-1:0][ADDR_WIDTH-1:0]     slave_addr_o,
  output logic [NSLAVE-1:0][DATA_WIDTH-1:0]     slave_wdata_o,
  input  logic [NSLAVE-1:0]                     slave_gnt_i,
  input  logic [NSLAVE-1:0]                     slave_rvalid_i,
  input  logic [NSLAVE-1:0][DATA_WIDTH-1:0]     slave_rdata_i
);

  // Error slave is the extra last output
  localparam int unsigned NOUT = NSLAVE + 1;
  localparam int unsigned SEL_WIDTH = $clog2(NOUT);

  logic [NMASTER-1:0][SEL_WIDTH-1:0]      port_sel;
  logic [NMASTER-1:0][REQ_DATA_WIDTH-1:0] master_word;
  logic [NOUT-1:0]                        xbar_req;
  logic [NOUT-1:0][REQ_DATA_WIDTH-1:0]    xbar_word;
  logic [NOUT-1:0]                        xbar_gnt;
  logic [NOUT-1:0]                        xbar_rvalid;
  logic [NOUT-1:0][DATA_WIDTH-1:0]        xbar_rdata;

  for (genvar i = 0; i < NMASTER; i++) begin : gen_master
    addr_decode #(
      .NSLAVE   (NSLAVE),
      .IDX_WIDTH(SEL_WIDTH)
    ) u_addr_decode (
      .addr_i     (master_addr_i[i]),
      .idx_o      (port_sel[i]),
      .dec_error_o()
    );

    assign master_word[i] = {master_we_i[i], master_be_i[i],
                             master_addr_i[i], master_wdata_i[i]};
  end

  xbar_varlat #(
    .NIN       (NMASTER),
    .NOUT      (NOUT),
    .REQ_WIDTH (REQ_DATA_WIDTH),
    .RESP_WIDTH(DATA_WIDTH)
  ) u_xbar (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (master_req_i),
    .sel_i   (port_sel),
    .wdata_i (master_word),
    .gnt_o   (master_gnt_o),
    .vld_o   (master_rvalid_o),
    .rdata_o (master_rdata_o),
    .req_o   (xbar_req),
    .wdata_o (xbar_word),
    .gnt_i   (xbar_gnt),
    .vld_i   (xbar_rvalid),
    .rdata_i (xbar_rdata)
  );

  for (genvar k = 0; k < NSLAVE; k++) begin : gen_slave
    assign slave_req_o[k] = xbar_req[k];
    assign {slave_we_o[k], slave_be_o[k], slave_addr_o[k], slave_wdata_o[k]} = xbar_word[k];
    assign xbar_gnt[k]    = slave_gnt_i[k];
    assign xbar_rvalid[k] = slave_rvalid_i[k];
    assign xbar_rdata[k]  = slave_rdata_i[k];
  end

  // Unmapped accesses end here
  err_slave u_err_slave (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (xbar_req[NSLAVE]),
    .gnt_o   (xbar_gnt[NSLAVE]),
    .rvalid_o(xbar_rvalid[NSLAVE]),
    .rdata_o (xbar_rdata[NSLAVE])
  );

endmodule : system_xbar

`default_nettype wire

// ==== bench/system_xbar_checker.sv ====
/* Crossbar protocol checker
   Concurrent assertions on routing, error responses, fairness,
   back-pressure and reset, bound into the system top */

`timescale 1ns/1ps
`default_nettype none

module system_xbar_checker
  import obi_xbar_pkg::*;
#(
  parameter int unsigned NMASTER = 3,
  parameter int unsigned NSLAVE = NUM_EXT_SLAVES
) (
  input logic                               clk_i,
  input logic                               arst_n_i,
  input logic [NMASTER-1:0]                 master_req_i,
  input logic [NMASTER-1:0]                 master_we_i,
  input logic [NMASTER-1:0]                 master_gnt_i,
  input logic [NMASTER-1:0]                 master_rvalid_i,
  input logic [NMASTER-1:0][BE_WIDTH-1:0]   master_be_i,
  input logic [NMASTER-1:0][ADDR_WIDTH-1:0] master_addr_i,
  input logic [NMASTER-1:0][DATA_WIDTH-1:0] master_wdata_i,
  input logic [NMASTER-1:0][DATA_WIDTH-1:0] master_rdata_i,
  input logic [NSLAVE-1:0]                  slave_req_i,
  input logic [NSLAVE-1:0]                  slave_we_i,
  input logic [NSLAVE-1:0]                  slave_gnt_i,
  input logic [NSLAVE-1:0][BE_WIDTH-1:0]    slave_be_i,
  input logic [NSLAVE-1:0][ADDR_WIDTH-1:0]  slave_addr_i,
  input logic [NSLAVE-1:0][DATA_WIDTH-1:0]  slave_wdata_i
);

  localparam int unsigned NOUT = NSLAVE + 1;

  int unsigned fail_count = 0;

  // Masters asking for each target and masters handed over to it
  logic [NOUT-1:0][NMASTER-1:0] want;
  logic [NOUT-1:0][NMASTER-1:0] xfer;
  logic [NOUT-1:0][NMASTER-1:0] last_q;
  logic [NOUT-1:0][NMASTER-1:0] wait_q;

  function automatic int unsigned target_of(input logic [ADDR_WIDTH-1:0] addr);
    int unsigned t;
    t = ERROR_IDX;
    for (int unsigned r = 0; r < NSLAVE; r++) begin
      if ((addr >= ADDR_RULES[r].start_addr) && (addr < ADDR_RULES[r].end_addr)) begin
        t = r;
      end
    end
    return t;
  endfunction

  always_comb begin
    for (int unsigned t = 0; t < NOUT; t++) begin
      for (int unsigned i = 0; i < NMASTER; i++) begin
        want[t][i] = master_req_i[i] && (target_of(master_addr_i[i]) == t);
        xfer[t][i] = want[t][i] && master_gnt_i[i];
      end
    end
  end

  // Last winner per target and who was left waiting since
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= '0;
      wait_q <= '0;
    end else begin
      for (int unsigned t = 0; t < NOUT; t++) begin
        if (|xfer[t]) begin
          last_q[t] <= xfer[t];
          wait_q[t] <= want[t] & ~xfer[t];
        end else begin
          wait_q[t] <= wait_q[t] & want[t];
        end
      end
    end
  end

  for (genvar k = 0; k < NSLAVE; k++) begin : gen_slave_chk
    // Also keeps unmapped accesses off the external ports
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      slave_req_i[k] |-> target_of(slave_addr_i[k]) == k)
    else begin
      fail_count++;
      $error("slave %0d request outside its address window", k);
    end
  end

  for (genvar i = 0; i < NMASTER; i++) begin : gen_master_chk
    for (genvar k = 0; k < NSLAVE; k++) begin : gen_route
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
        xfer[k][i] |-> slave_req_i[k] && slave_gnt_i[k] &&
          slave_addr_i[k] == master_addr_i[i] && slave_we_i[k] == master_we_i[i] &&
          slave_be_i[k] == master_be_i[i] && slave_wdata_i[k] == master_wdata_i[i])
      else begin
        fail_count++;
        $error("master %0d payload not forwarded to slave %0d", i, k);
      end

      // Stalled slave blocks every master routed to it
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
        want[k][i] && !slave_gnt_i[k] |-> !master_gnt_i[i])
      else begin
        fail_count++;
        $error("master %0d granted while slave %0d stalls", i, k);
      end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      xfer[ERROR_IDX][i] |=> master_rvalid_i[i] && master_rdata_i[i] == ERR_RDATA)
    else begin
      fail_count++;
      $error("master %0d missing error response", i);
    end
  end

  for (genvar t = 0; t < NOUT; t++) begin : gen_fair_chk
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      |xfer[t] |-> !((|(xfer[t] & last_q[t])) && (|(wait_q[t] & want[t]))))
    else begin
      fail_count++;
      $error("target %0d granted the same master twice while another waits", t);
    end
  end

  // Quiet outputs in reset and the first cycle after it
  assert property (@(posedge clk_i)
    (!arst_n_i || !$past(arst_n_i)) |->
      master_gnt_i == '0 && master_rvalid_i == '0 && slave_req_i == '0)
  else begin
    fail_count++;
    $error("outputs active during or right after reset");
  end

endmodule : system_xbar_checker

bind system_xbar system_xbar_checker #(
  .NMASTER(NMASTER),
  .NSLAVE (NSLAVE)
) u_checker (
  .clk_i, .arst_n_i, .master_req_i, .master_we_i, .master_be_i,
  .master_addr_i, .master_wdata_i,
  .master_gnt_i   (master_gnt_o),
  .master_rvalid_i(master_rvalid_o),
  .master_rdata_i (master_rdata_o),
  .slave_req_i    (slave_req_o),
  .slave_we_i     (slave_we_o),
  .slave_be_i     (slave_be_o),
  .slave_addr_i   (slave_addr_o),
  .slave_wdata_i  (slave_wdata_o),
  .slave_gnt_i
);

`default_nettype wire

// ==== bench/system_xbar_tb.sv ====
/* Crossbar testbench
   Three random masters and three in-order slave models around the
   system interconnect, with the response data checked per master */

`timescale 1ns/1ps
`default_nettype none

module system_xbar_tb
  import obi_xbar_pkg::*;
();

  localparam int unsigned NM = 3;
  localparam int unsigned NS = NUM_EXT_SLAVES;
  localparam int unsigned OPS = 40;
  localparam int unsigned TIMEOUT = 200;

  logic                          clk_i;
  logic                          arst_n_i;
  logic [NM-1:0]                 master_req_i;
  logic [NM-1:0]                 master_we_i;
  logic [NM-1:0][BE_WIDTH-1:0]   master_be_i;
  logic [NM-1:0][ADDR_WIDTH-1:0] master_addr_i;
  logic [NM-1:0][DATA_WIDTH-1:0] master_wdata_i;
  logic [NM-1:0]                 master_gnt_o;
  logic [NM-1:0]                 master_rvalid_o;
  logic [NM-1:0][DATA_WIDTH-1:0] master_rdata_o;
  logic [NS-1:0]                 slave_req_o;
  logic [NS-1:0]                 slave_we_o;
  logic [NS-1:0][BE_WIDTH-1:0]   slave_be_o;
  logic [NS-1:0][ADDR_WIDTH-1:0] slave_addr_o;
  logic [NS-1:0][DATA_WIDTH-1:0] slave_wdata_o;
  wire  [NS-1:0]                 slave_gnt_i;
  wire  [NS-1:0]                 slave_rvalid_i;
  wire  [NS-1:0][DATA_WIDTH-1:0] slave_rdata_i;

  int unsigned data_errors = 0;
  int unsigned timeouts = 0;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  system_xbar dut (.*);

  // In-order slaves with random stalls and 1 to 3 cycles of latency
  for (genvar k = 0; k < NS; k++) begin : gen_slave_model
    logic                  gnt_q = 1'b0;
    logic                  rvalid_q = 1'b0;
    logic [DATA_WIDTH-1:0] rdata_q = '0;
    logic [DATA_WIDTH-1:0] resp_q [$];
    int unsigned           delay_q [$];

    assign slave_gnt_i[k]    = gnt_q;
    assign slave_rvalid_i[k] = rvalid_q;
    assign slave_rdata_i[k]  = rdata_q;

    // Capture accepted transfers mid-cycle
    always @(negedge clk_i) begin
      if (slave_req_o[k] && slave_gnt_i[k]) begin
        resp_q.push_back(slave_addr_o[k] ^ (DATA_WIDTH'(k) << 24));
        delay_q.push_back($urandom_range(1, 3));
      end
    end

    always @(posedge clk_i) begin
      gnt_q    <= arst_n_i && ($urandom_range(0, 3) != 0);
      rvalid_q <= 1'b0;
      if (delay_q.size() > 0) begin
        if (delay_q[0] > 1) begin
          delay_q[0] = delay_q[0] - 1;
        end else begin
          rvalid_q <= 1'b1;
          rdata_q  <= resp_q.pop_front();
          void'(delay_q.pop_front());
        end
      end
    end
  end

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = dut.u_checker.fail_count;
    $display("data errors: %0d, assertion failures: %0d, timeouts: %0d",
             data_errors, assert_fails, timeouts);
    if (data_errors == 0 && assert_fails == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // Next request only after the previous rvalid
  task automatic run_master(input int unsigned m);
    int unsigned           region;
    int unsigned           waited;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] expected;
    string                 test_name;
    for (int unsigned n = 0; n < OPS; n++) begin
      region = $urandom_range(0, 3);
      case (region)
        0: addr = {16'h0000, 16'($urandom)};
        1: addr = {16'h0001, 16'($urandom)};
        2: addr = {20'h20000, 12'($urandom)};
        default: addr = {4'h8, 28'($urandom)};
      endcase
      addr[1:0] = 2'b00;
      expected  = (region == 3) ? ERR_RDATA : (addr ^ (DATA_WIDTH'(region) << 24));
      test_name = (region == 3) ? "error_slave" : "response_return";

      @(posedge clk_i);
      master_req_i[m]   <= 1'b1;
      master_we_i[m]    <= 1'($urandom);
      master_be_i[m]    <= 4'($urandom);
      master_addr_i[m]  <= addr;
      master_wdata_i[m] <= $urandom;
      waited = 0;
      do begin
        @(negedge clk_i);
        waited++;
      end while (!master_gnt_o[m] && waited < TIMEOUT);
      if (!master_gnt_o[m]) begin
        $display("master %0d stalled waiting for gnt", m);
        timeouts++;
        return;
      end

      @(posedge clk_i);
      master_req_i[m] <= 1'b0;
      waited = 0;
      do begin
        @(negedge clk_i);
        waited++;
      end while (!master_rvalid_o[m] && waited < TIMEOUT);
      if (!master_rvalid_o[m]) begin
        $display("master %0d stalled waiting for rvalid", m);
        timeouts++;
        return;
      end else if (master_rdata_o[m] !== expected) begin
        data_errors++;
        $display("ERROR %s master %0d expected %08h actual %08h",
                 test_name, m, expected, master_rdata_o[m]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hcccf));
    arst_n_i       = 1'b0;
    master_req_i   = '0;
    master_we_i    = '0;
    master_be_i    = '0;
    master_addr_i  = '0;
    master_wdata_i = '0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    fork
      run_master(0);
      run_master(1);
      run_master(2);
    join
    repeat (5) @(posedge clk_i);
    finish_run();
  end

endmodule : system_xbar_tb

`default_nettype wire

// ==== obi_xbar.f ====
src/obi_xbar_pkg.sv
src/addr_decode.sv
src/rr_arbiter.sv
src/xbar_varlat.sv
src/err_slave.sv
src/system_xbar.sv
bench/system_xbar_checker.sv
bench/system_xbar_tb.sv
